// ==== source/codecPkg.sv ====
// codec parameter defaults, width typedefs and the model bounds struct
package codecPkg;

    localparam int PRECISION = 12;     // width of the whole coding interval
    localparam int NUM_SYMBOLS = 257;  // alphabet size, eof included
    localparam int EOF_SYMBOL = 256;   // closes a stream

    // interval low bound, high bound and width
    typedef logic [PRECISION-1:0] codeT;

    // cumulative frequency or total count
    typedef logic [PRECISION-4:0] countT;

    // symbol index
    typedef logic [$clog2(NUM_SYMBOLS)-1:0] symbolT;

    // width times count, also the divider quotient
    typedef logic [2*PRECISION-2:0] productT;

    // one packed output word
    typedef logic [31:0] wordT;

    // model answer for the current symbol
    typedef struct packed {
        countT cumLow;   // start of the symbol's range
        countT cumHigh;  // end of the symbol's range
        countT total;    // sum of all counts
    } modelBoundsT;

endpackage

// ==== source/symbolModel.sv ====
// adaptive cumulative-frequency table that stops adapting at the freeze limit
`timescale 1ns/1ns

module symbolModel import codecPkg::*; #(
    parameter int PRECISION = codecPkg::PRECISION,
    parameter int NUM_SYMBOLS = codecPkg::NUM_SYMBOLS
) (
    input logic clk,
    input logic rstn,
    input logic clear,
    input logic update,
    input symbolT symbol,
    output modelBoundsT bounds
);

    // adaptation stops once the total hits a quarter of the interval minus one
    localparam countT freezeLimit = countT'(2 ** (PRECISION - 3) - 1);

    // entry i is where symbol i begins and symbol i-1 ends, the last entry is the total
    countT cumTable [0:NUM_SYMBOLS];
    logic frozen;

    assign frozen = (cumTable[NUM_SYMBOLS] == freezeLimit);

    assign bounds.cumLow = cumTable[symbol];
    assign bounds.cumHigh = cumTable[symbol + 1'b1];
    assign bounds.total = cumTable[NUM_SYMBOLS];

    always_ff @(posedge clk) begin
        if (!rstn || clear) begin
            for (int i = 0; i <= NUM_SYMBOLS; i++) begin
                cumTable[i] <= countT'(i);  // every symbol starts with a count of one
            end
        end else if (update && !frozen) begin
            // the symbol's end and every higher boundary move up by one
            for (int i = 1; i <= NUM_SYMBOLS; i++) begin
                if (i > int'(symbol)) begin
                    cumTable[i] <= cumTable[i] + 1'b1;
                end
            end
        end
    end

    // a symbol always owns a non-empty range, so the coder never gets a zero-width subinterval
    assert property (@(posedge clk) disable iff (!rstn)
        bounds.cumLow < bounds.cumHigh);

endmodule

// ==== source/boundDivider.sv ====
// multiply-then-divide unit that scales one interval bound by count over total
`timescale 1ns/1ns

module boundDivider import codecPkg::*; #(
    parameter int PRECISION = codecPkg::PRECISION
) (
    input logic clk,
    input logic rstn,
    input logic divStart,
    input codeT width,
    input countT count,
    input countT total,
    output productT quotient,
    output logic done
);

    localparam int STEPS = 2 * PRECISION - 1;  // one quotient bit per cycle

    productT work;       // dividend shifting out, quotient shifting in
    countT divisor;
    countT remainder;
    logic [$bits(countT):0] trial;
    logic fits;
    logic busy;
    logic [$clog2(STEPS + 1)-1:0] stepsLeft;

    assign trial = {remainder, work[$bits(productT)-1]};
    assign fits = (trial >= {1'b0, divisor});
    assign quotient = work;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            stepsLeft <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (divStart) begin
                busy <= 1'b1;
                stepsLeft <= STEPS[$bits(stepsLeft)-1:0];
            end else if (busy) begin
                stepsLeft <= stepsLeft - 1'b1;
                if (stepsLeft == 1) begin  // last quotient bit goes in this cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // restoring division datapath
    always_ff @(posedge clk) begin
        if (divStart) begin
            work <= productT'(width) * productT'(count);
            divisor <= total;
            remainder <= '0;
        end else if (busy) begin
            work <= {work[$bits(productT)-2:0], fits};
            remainder <= fits ? countT'(trial - {1'b0, divisor}) : countT'(trial);
        end
    end

    // the model must never hand over an empty table
    assert property (@(posedge clk) disable iff (!rstn)
        divStart |-> total != '0);

endmodule

// ==== source/intervalCoder.sv ====
// encoder FSM with subinterval update, renormalisation, pending bits and flush
`timescale 1ns/1ns

module intervalCoder import codecPkg::*; #(
    parameter int PRECISION = codecPkg::PRECISION,
    parameter int EOF_SYMBOL = codecPkg::EOF_SYMBOL
) (
    input logic clk,
    input logic rstn,
    input logic start,
    input wordT inputBits,
    input logic newBitsProvided,
    output logic idle,
    output logic newBitsRequested,
    output symbolT symbol,
    output logic modelClear,
    output logic update,
    output logic divStart,
    output codeT width,
    input productT lowQuotient,
    input productT highQuotient,
    input logic divDone,
    input logic full,
    output logic bitValid,
    output logic bitValue,
    output logic flush
);

    localparam codeT whole = codeT'(2 ** (PRECISION - 1));
    localparam codeT half = codeT'(2 ** (PRECISION - 2));
    localparam codeT quarter = codeT'(2 ** (PRECISION - 3));
    localparam codeT threeQuarters = codeT'(3 * 2 ** (PRECISION - 3));

    typedef enum logic [2:0] {
        IDLE, DIVIDE, RENORM, PENDING, REQUEST, RELEASE, FLUSH, FINISH
    } stateT;

    stateT state;
    codeT low;
    codeT high;
    logic [7:0] pending;  // middle expansions not yet resolved
    logic pendingBit;
    logic closing;        // closing bits of the stream are going out
    logic lastSymbol;
    logic leftCase;
    logic rightCase;
    logic middleCase;
    logic closeCase;
    logic emitBit;

    assign lastSymbol = (symbol == symbolT'(EOF_SYMBOL));
    assign leftCase = (high < half);
    assign rightCase = (low > half);
    assign middleCase = (low > quarter) && (high < threeQuarters);
    assign closeCase = !leftCase && !rightCase && !middleCase && lastSymbol;
    assign emitBit = leftCase ? 1'b0 : (rightCase ? 1'b1 : (low > quarter));

    assign idle = (state == IDLE);
    assign modelClear = idle && start;
    assign width = high - low;
    assign bitValid = !full && ((state == PENDING)
                      || (state == RENORM && (leftCase || rightCase || closeCase)));
    assign bitValue = (state == PENDING) ? pendingBit : emitBit;
    assign flush = !full && (state == FLUSH);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            low <= '0;
            high <= whole;
            symbol <= '0;
            pending <= '0;
            pendingBit <= 1'b0;
            closing <= 1'b0;
            newBitsRequested <= 1'b0;
            divStart <= 1'b0;
            update <= 1'b0;
        end else begin
            divStart <= 1'b0;
            update <= 1'b0;
            unique case (state)
                IDLE: if (start) begin
                    low <= '0;
                    high <= whole;
                    pending <= '0;
                    closing <= 1'b0;
                    symbol <= symbolT'(inputBits);  // first symbol comes with start
                    divStart <= 1'b1;
                    state <= DIVIDE;
                end
                DIVIDE: if (divDone) begin  // both dividers finish together
                    high <= low + codeT'(highQuotient);
                    low <= low + codeT'(lowQuotient);
                    update <= !lastSymbol;
                    state <= RENORM;
                end
                RENORM: if (!full) begin
                    if (leftCase) begin
                        low <= low << 1;
                        high <= high << 1;
                    end else if (rightCase) begin
                        low <= (low - half) << 1;
                        high <= (high - half) << 1;
                    end else if (middleCase) begin
                        low <= (low - quarter) << 1;
                        high <= (high - quarter) << 1;
                        pending <= pending + 1'b1;
                    end else if (lastSymbol) begin
                        pending <= pending + 1'b1;  // closing bit is followed by pending+1 opposites
                        closing <= 1'b1;
                        state <= PENDING;
                    end else begin
                        newBitsRequested <= 1'b1;
                        state <= REQUEST;
                    end
                    if (leftCase || rightCase || closeCase) begin
                        pendingBit <= !emitBit;
                    end
                    if ((leftCase || rightCase) && pending != '0) begin
                        state <= PENDING;
                    end
                end
                PENDING: if (!full) begin
                    pending <= pending - 1'b1;
                    if (pending == 8'd1) begin
                        state <= closing ? FLUSH : RENORM;
                    end
                end
                REQUEST: if (newBitsProvided) begin
                    newBitsRequested <= 1'b0;
                    symbol <= symbolT'(inputBits);
                    state <= RELEASE;
                end
                RELEASE: if (!newBitsProvided) begin
                    divStart <= 1'b1;
                    state <= DIVIDE;
                end
                FLUSH: if (!full) begin
                    state <= FINISH;
                end
                FINISH: if (!full) begin  // last word has been read
                    state <= IDLE;
                end
            endcase
        end
    end

    // the scaled quotients must leave a non-empty subinterval
    assert property (@(posedge clk) disable iff (!rstn)
        (state == DIVIDE && divDone) |=> high > low);

endmodule

// ==== source/outputPacker.sv ====
// packs coded bits into 32-bit words and runs the read acknowledge exchange
`timescale 1ns/1ns

module outputPacker import codecPkg::*; (
    input logic clk,
    input logic rstn,
    input logic bitValid,
    input logic bitValue,
    input logic flush,
    input logic readSuccess,
    output logic full,
    output logic resultReady,
    output wordT out,
    output logic [2:0] validOutputBytes
);

    logic [4:0] bitPos;    // next free bit, filled from bit 0 upwards
    logic waitRelease;     // word taken, waiting for readSuccess to drop

    assign full = resultReady || waitRelease;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bitPos <= '0;
            waitRelease <= 1'b0;
            resultReady <= 1'b0;
            out <= '0;
            validOutputBytes <= 3'd4;
        end else if (resultReady) begin
            if (readSuccess) begin
                resultReady <= 1'b0;
                waitRelease <= 1'b1;
                out <= '0;
                bitPos <= '0;
            end
        end else if (waitRelease) begin
            if (!readSuccess) begin
                waitRelease <= 1'b0;
                validOutputBytes <= 3'd4;
            end
        end else if (bitValid) begin
            out[bitPos] <= bitValue;
            bitPos <= bitPos + 1'b1;
            if (bitPos == 5'd31) begin
                resultReady <= 1'b1;
            end
        end else if (flush && bitPos != '0) begin  // an empty word is not sent
            resultReady <= 1'b1;
            validOutputBytes <= 3'((6'(bitPos) + 6'd7) >> 3);  // started bytes
        end
    end

endmodule

// ==== source/arithmeticEncoder.sv ====
// encoder top level wiring the model, both bound dividers, the coder and the packer
`timescale 1ns/1ns

module arithmeticEncoder import codecPkg::*; #(
    parameter int PRECISION = codecPkg::PRECISION,
    parameter int NUM_SYMBOLS = codecPkg::NUM_SYMBOLS,
    parameter int EOF_SYMBOL = codecPkg::EOF_SYMBOL
) (
    input logic clk,
    input logic rstn,
    input logic start,
    input wordT inputBits,
    input logic newBitsProvided,
    input logic readSuccess,
    output logic idle,
    output logic resultReady,
    output logic newBitsRequested,
    output logic [2:0] validOutputBytes,
    output wordT out
);

    symbolT symbol;
    modelBoundsT bounds;
    logic modelClear;
    logic update;
    logic divStart;
    codeT width;
    productT lowQuotient;
    productT highQuotient;
    logic divDone;
    logic full;
    logic bitValid;
    logic bitValue;
    logic flush;

    symbolModel #(
        .PRECISION(PRECISION),
        .NUM_SYMBOLS(NUM_SYMBOLS)
    ) model (
        .clk(clk),
        .rstn(rstn),
        .clear(modelClear),
        .update(update),
        .symbol(symbol),
        .bounds(bounds)
    );

    boundDivider #(.PRECISION(PRECISION)) divLow (
        .clk(clk),
        .rstn(rstn),
        .divStart(divStart),
        .width(width),
        .count(bounds.cumLow),
        .total(bounds.total),
        .quotient(lowQuotient),
        .done(divDone)
    );

    // fixed latency, so it finishes together with divLow
    boundDivider #(.PRECISION(PRECISION)) divHigh (
        .clk(clk),
        .rstn(rstn),
        .divStart(divStart),
        .width(width),
        .count(bounds.cumHigh),
        .total(bounds.total),
        .quotient(highQuotient),
        .done()
    );

    intervalCoder #(
        .PRECISION(PRECISION),
        .EOF_SYMBOL(EOF_SYMBOL)
    ) coder (
        .clk(clk),
        .rstn(rstn),
        .start(start),
        .inputBits(inputBits),
        .newBitsProvided(newBitsProvided),
        .idle(idle),
        .newBitsRequested(newBitsRequested),
        .symbol(symbol),
        .modelClear(modelClear),
        .update(update),
        .divStart(divStart),
        .width(width),
        .lowQuotient(lowQuotient),
        .highQuotient(highQuotient),
        .divDone(divDone),
        .full(full),
        .bitValid(bitValid),
        .bitValue(bitValue),
        .flush(flush)
    );

    outputPacker packer (
        .clk(clk),
        .rstn(rstn),
        .bitValid(bitValid),
        .bitValue(bitValue),
        .flush(flush),
        .readSuccess(readSuccess),
        .full(full),
        .resultReady(resultReady),
        .out(out),
        .validOutputBytes(validOutputBytes)
    );

endmodule

// ==== bench/encoderChecker.sv ====
// checker that compares acknowledged DUT words, byte counts and idle outputs
`timescale 1ns/1ns

module encoderChecker import codecPkg::*; (
    input logic clk,
    input logic rstn,
    input logic idle,
    input logic resultReady,
    input logic readSuccess,
    input logic newBitsRequested,
    input wordT out,
    input logic [2:0] validOutputBytes
);

    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testErrors = 0;
    int wordsSeen = 0;
    int expBytes[$];    // byte count for each word still to come
    wordT expWords[$];

    task expectWord(input int bytes, input wordT word);
        expBytes.push_back(bytes);
        expWords.push_back(word);
    endtask

    task finishTest(input int testNum);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        errorCount += testErrors;
        $display("test %0d done: %0d words, %0d errors", testNum, wordsSeen, testErrors);
        testErrors = 0;
        wordsSeen = 0;
    endtask

    // outputs right after reset
    task checkIdleState(input int testNum);
        if (idle !== 1'b1 || resultReady !== 1'b0 || newBitsRequested !== 1'b0) begin
            $display("FAIL at %0t ns: idle %b resultReady %b newBitsRequested %b after reset",
                $time, idle, resultReady, newBitsRequested);
            testErrors++;
        end
        if (validOutputBytes !== 3'd4) begin
            $display("FAIL at %0t ns: validOutputBytes %0d after reset, expected 4",
                $time, validOutputBytes);
            testErrors++;
        end
        finishTest(testNum);
    endtask

    task closeTest(input int testNum);
        if (expWords.size() != 0) begin
            $display("test %0d ended with %0d expected words never delivered",
                testNum, expWords.size());
            testErrors++;
            expWords.delete();
            expBytes.delete();
        end
        finishTest(testNum);
    endtask

    // a word counts as read on the edge where the host acknowledges it
    always @(posedge clk) begin
        if (rstn && resultReady && readSuccess) begin
            wordsSeen++;
            if (expWords.size() == 0) begin
                $display("the DUT delivered a word %h that no test expected", out);
                testErrors++;
            end else begin
                if (out !== expWords[0]) begin
                    $display("FAIL at %0t ns: word %h, expected %h", $time, out, expWords[0]);
                    testErrors++;
                end
                if ({29'd0, validOutputBytes} !== expBytes[0]) begin
                    $display("FAIL at %0t ns: validOutputBytes %0d, expected %0d",
                        $time, validOutputBytes, expBytes[0]);
                    testErrors++;
                end
                void'(expWords.pop_front());
                void'(expBytes.pop_front());
            end
        end
    end

endmodule

// ==== bench/tbEncoder.sv ====
// encoder testbench with clock, reset, file-driven streams, random delays and watchdog
`timescale 1ns/1ns

module tbEncoder import codecPkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 4;
    localparam int MEM_DEPTH = 64;
    localparam string STIM_FILE = "bench/encoderStimulus.txt";

    logic clk;
    logic rstn;
    logic start;
    wordT inputBits;
    logic newBitsProvided;
    logic readSuccess;
    logic idle;
    logic resultReady;
    logic newBitsRequested;
    logic [2:0] validOutputBytes;
    wordT out;

    logic [31:0] stim [0:MEM_DEPTH-1];
    logic [15:0] ackState;      // separate generators for the two host sides
    logic [15:0] provideState;
    int limitCycles = 0;
    int stimPos;

    arithmeticEncoder UUT (
        .clk(clk),
        .rstn(rstn),
        .start(start),
        .inputBits(inputBits),
        .newBitsProvided(newBitsProvided),
        .readSuccess(readSuccess),
        .idle(idle),
        .resultReady(resultReady),
        .newBitsRequested(newBitsRequested),
        .validOutputBytes(validOutputBytes),
        .out(out)
    );

    encoderChecker scoreboard (
        .clk(clk),
        .rstn(rstn),
        .idle(idle),
        .resultReady(resultReady),
        .readSuccess(readSuccess),
        .newBitsRequested(newBitsRequested),
        .out(out),
        .validOutputBytes(validOutputBytes)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // three bits give a delay of 0 to 7 cycles
    task drawDelay(inout logic [15:0] state, output int delay);
        delay = 0;
        for (int i = 0; i < 3; i++) begin
            state = lfsrStep(state);
            delay = delay * 2 + int'(state[0]);
        end
    endtask

    function automatic int countSymbols();
        int pos;
        int total;
        pos = 0;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += stim[pos];
            pos += stim[pos] + 2 + 2 * stim[pos + stim[pos] + 1];
        end
        return total;
    endfunction

    // one stream from the data file, symbols first, then the expected words
    task runTest(input int testNum, inout int pos);
        int numSymbols;
        int numWords;
        int delay;
        numSymbols = stim[pos];
        numWords = stim[pos + numSymbols + 1];
        for (int w = 0; w < numWords; w++) begin
            scoreboard.expectWord(stim[pos + numSymbols + 2 + 2 * w],
                stim[pos + numSymbols + 3 + 2 * w]);
        end
        @(posedge clk);
        start <= 1'b1;
        inputBits <= stim[pos + 1];
        @(posedge clk);
        start <= 1'b0;
        for (int s = 1; s < numSymbols; s++) begin
            do @(posedge clk); while (!newBitsRequested);
            drawDelay(provideState, delay);
            repeat (delay) @(posedge clk);
            inputBits <= stim[pos + 1 + s];
            newBitsProvided <= 1'b1;
            do @(posedge clk); while (newBitsRequested);
            newBitsProvided <= 1'b0;
        end
        do @(posedge clk); while (!idle);
        scoreboard.closeTest(testNum);
        pos += numSymbols + 2 + 2 * numWords;
    endtask

    // host side of the read acknowledge
    always begin
        int delay;
        @(posedge clk);
        if (rstn && resultReady && !readSuccess) begin
            drawDelay(ackState, delay);
            repeat (delay) @(posedge clk);
            readSuccess <= 1'b1;
            do @(posedge clk); while (resultReady);
            readSuccess <= 1'b0;
        end
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        start = 1'b0;
        inputBits = '0;
        newBitsProvided = 1'b0;
        readSuccess = 1'b0;
        ackState = 16'd22;
        provideState = 16'd22;
        $readmemh(STIM_FILE, stim);
        limitCycles = countSymbols() * 400 + 2000;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        scoreboard.checkIdleState(1);
        stimPos = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t + 2, stimPos);
        end
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors",
            scoreboard.testsRun, scoreboard.testsFailed, scoreboard.errorCount);
        if (scoreboard.errorCount == 0 && scoreboard.testErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the symbol count in the data file
    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles) @(posedge clk);
        $display("the run did not finish within %0d cycles", limitCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== bench/encoderStimulus.txt ====
// each test: symbol count, symbols, word count, then byte count and word for each word
// all values hex, symbol 100 is the end of stream
// eof only
1 100
1 2 000000FF
// short stream, one partial word
2 0 100
1 3 0001FB00
// five zero symbols spill into a second word
6 0 0 0 0 0 100
2 4 00000000 2 000003EA
// short stream again, start must clear the model
2 0 100
1 3 0001FB00

// ==== project.f ====
source/codecPkg.sv
source/symbolModel.sv
source/boundDivider.sv
source/intervalCoder.sv
source/outputPacker.sv
source/arithmeticEncoder.sv
bench/encoderChecker.sv
bench/tbEncoder.sv

// ==== Bender.yml ====
package:
  name: arithmetic_encoder

sources:
  - files:
      - source/codecPkg.sv
      - source/symbolModel.sv
      - source/boundDivider.sv
      - source/intervalCoder.sv
      - source/outputPacker.sv
      - source/arithmeticEncoder.sv
  - target: test
    files:
      - bench/encoderChecker.sv
      - bench/tbEncoder.sv
